/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := codec_tb
DUT_TOP   := pcm_codec_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation of $(DUT_TOP) failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
hdl/codec_pkg.sv
hdl/codec_ctrl.sv
hdl/mulaw_encoder.sv
hdl/mulaw_decoder.sv
hdl/pcm_codec_top.sv
verif/codec_tb.sv

/* hdl/codec_ctrl.sv */
// codec controller: splits strobes by opcode, aligns both paths, merges results in order
`timescale 1ns/1ns
`default_nettype none

module codec_ctrl import codec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               sample_valid,
    input  wire op_t          op,
    input  wire [PCM_W-1:0]   pcm_in,
    input  wire [CODE_W-1:0]  code_in,
    input  wire [CODE_W-1:0]  enc_code,
    input  wire               enc_done,
    input  wire [PCM_W-1:0]   dec_pcm,
    input  wire               dec_done,
    output logic              enc_valid,
    output logic [PCM_W-1:0]  enc_pcm,
    output logic              dec_valid,
    output logic [CODE_W-1:0] dec_code,
    output logic [CODE_W-1:0] code_out,
    output logic [PCM_W-1:0]  pcm_out,
    output logic              out_valid,
    output logic              busy
);

    logic                dec_cap_valid;
    logic [CODE_W-1:0]   dec_cap_code;
    logic [PIPE_LAT-1:0] occ;

    // input capture and opcode split
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enc_valid     <= 1'b0;
            dec_cap_valid <= 1'b0;
        end else begin
            enc_valid     <= sample_valid && (op == OP_ENCODE);
            dec_cap_valid <= sample_valid && (op == OP_DECODE);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            enc_pcm      <= pcm_in;
            dec_cap_code <= code_in;
        end
    end

    // decoder is one stage shorter, so the decode path waits a cycle here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= dec_cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_code <= dec_cap_code;
    end

    // only the matching data output moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            code_out  <= '0;
            pcm_out   <= '0;
        end else begin
            out_valid <= enc_done | dec_done;
            if (enc_done) begin
                code_out <= enc_code;
            end
            if (dec_done) begin
                pcm_out <= dec_pcm;
            end
        end
    end

    // one bit per in-flight slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= '0;
        end else begin
            occ <= {occ[PIPE_LAT-2:0], sample_valid};
        end
    end

    assign busy = |occ;

    a_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(enc_done && dec_done))
        else $error("encoder and decoder finished in the same cycle");

    // out_valid loads PIPE_LAT edges after the strobe edge and is seen one edge later
    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> ##(PIPE_LAT + 1) out_valid)
        else $error("out_valid missing %0d cycles after strobe", PIPE_LAT);

endmodule

`default_nettype wire

/* hdl/codec_pkg.sv */
// codec package: opcode type, sample widths and mu-law constants
`default_nettype none

package codec_pkg;

    // strobe opcode
    typedef enum logic {
        OP_DECODE = 1'b0,
        OP_ENCODE = 1'b1
    } op_t;

    // linear sample and code widths
    localparam int PCM_W  = 16;
    localparam int CODE_W = 8;

    // added to the magnitude before the segment search
    localparam int MULAW_BIAS = 132;

    // largest magnitude kept before biasing
    localparam int MULAW_CLIP = 32635;

    // strobe to out_valid, in cycles
    localparam int PIPE_LAT = 4;

endpackage

`default_nettype wire

/* hdl/mulaw_decoder.sv */
// mu-law decoder: two-stage pipeline from 8-bit code to signed linear sample
`timescale 1ns/1ns
`default_nettype none

module mulaw_decoder import codec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               dec_valid,
    input  wire [CODE_W-1:0]  dec_code,
    output logic [PCM_W-1:0]  dec_pcm,
    output logic              dec_done
);

    localparam int MAG_W       = PCM_W - 1;
    localparam int DEC_MAG_MAX = 32124;

    logic [CODE_W-1:0] inv;
    logic [MAG_W-1:0]  base;
    logic              d1_valid;
    logic              d1_sign;
    logic [MAG_W-1:0]  d1_mag;
    logic [MAG_W-1:0]  mag;

    // mantissa times 8 plus bias, before the segment shift
    assign inv  = ~dec_code;
    assign base = MAG_W'({inv[3:0], 3'b000}) + MAG_W'(MULAW_BIAS);
    assign mag  = d1_mag - MAG_W'(MULAW_BIAS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d1_valid <= 1'b0;
            dec_done <= 1'b0;
        end else begin
            d1_valid <= dec_valid;
            dec_done <= d1_valid;
        end
    end

    always_ff @(posedge clk) begin
        d1_sign <= inv[CODE_W-1];
        d1_mag  <= base << inv[6:4];
        dec_pcm <= d1_sign ? -{1'b0, mag} : {1'b0, mag};
    end

    a_mag_range: assert property (@(posedge clk) disable iff (!rst_n)
        d1_valid |-> (mag <= MAG_W'(DEC_MAG_MAX)))
        else $error("decoded magnitude out of range: %0d", mag);

endmodule

`default_nettype wire

/* hdl/mulaw_encoder.sv */
// mu-law encoder: three-stage pipeline from signed linear sample to 8-bit code
`timescale 1ns/1ns
`default_nettype none

module mulaw_encoder import codec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               enc_valid,
    input  wire [PCM_W-1:0]   enc_pcm,
    output logic [CODE_W-1:0] enc_code,
    output logic              enc_done
);

    localparam int MAG_W = PCM_W - 1;

    logic [MAG_W-1:0] mag_abs;
    logic [MAG_W-1:0] mag_clip;
    logic             s1_valid;
    logic             s1_sign;
    logic [PCM_W-1:0] s1_mag;
    logic [2:0]       seg;
    logic             s2_valid;
    logic             s2_sign;
    logic [PCM_W-1:0] s2_mag;
    logic [2:0]       s2_seg;
    logic [PCM_W-1:0] shifted;

    // most negative sample maps to full scale
    always_comb begin
        if (!enc_pcm[PCM_W-1]) begin
            mag_abs = enc_pcm[MAG_W-1:0];
        end else if (enc_pcm[MAG_W-1:0] == '0) begin
            mag_abs = '1;
        end else begin
            mag_abs = ~enc_pcm[MAG_W-1:0] + 1'b1;
        end
        mag_clip = (mag_abs > MAG_W'(MULAW_CLIP)) ? MAG_W'(MULAW_CLIP) : mag_abs;
    end

    // the bias keeps some bit in 14..7 set
    always_comb begin
        seg = '0;
        for (int i = 0; i < 8; i++) begin
            if (s1_mag[7 + i]) begin
                seg = 3'(i);
            end
        end
    end

    // four bits just below the leading one
    assign shifted = s2_mag >> ({1'b0, s2_seg} + 4'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            s1_valid <= enc_valid;
            s2_valid <= s1_valid;
            enc_done <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sign  <= enc_pcm[PCM_W-1];
        s1_mag   <= PCM_W'(mag_clip) + PCM_W'(MULAW_BIAS);
        s2_sign  <= s1_sign;
        s2_mag   <= s1_mag;
        s2_seg   <= seg;
        enc_code <= ~{s2_sign, s2_seg, shifted[3:0]};
    end

    a_mag_range: assert property (@(posedge clk) disable iff (!rst_n)
        s2_valid |-> (s2_mag <= PCM_W'(MULAW_CLIP + MULAW_BIAS)))
        else $error("biased magnitude out of range: %0d", s2_mag);

endmodule

`default_nettype wire

/* hdl/pcm_codec_top.sv */
// mu-law PCM codec top: controller with encoder and decoder pipelines
`timescale 1ns/1ns
`default_nettype none

module pcm_codec_top import codec_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               sample_valid,
    input  wire op_t          op,
    input  wire [PCM_W-1:0]   pcm_in,
    input  wire [CODE_W-1:0]  code_in,
    output wire [CODE_W-1:0]  code_out,
    output wire [PCM_W-1:0]   pcm_out,
    output wire               out_valid,
    output wire               busy
);

    wire              enc_valid;
    wire [PCM_W-1:0]  enc_pcm;
    wire [CODE_W-1:0] enc_code;
    wire              enc_done;
    wire              dec_valid;
    wire [CODE_W-1:0] dec_code;
    wire [PCM_W-1:0]  dec_pcm;
    wire              dec_done;

    codec_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .op           (op),
        .pcm_in       (pcm_in),
        .code_in      (code_in),
        .enc_code     (enc_code),
        .enc_done     (enc_done),
        .dec_pcm      (dec_pcm),
        .dec_done     (dec_done),
        .enc_valid    (enc_valid),
        .enc_pcm      (enc_pcm),
        .dec_valid    (dec_valid),
        .dec_code     (dec_code),
        .code_out     (code_out),
        .pcm_out      (pcm_out),
        .out_valid    (out_valid),
        .busy         (busy)
    );

    mulaw_encoder u_enc (
        .clk       (clk),
        .rst_n     (rst_n),
        .enc_valid (enc_valid),
        .enc_pcm   (enc_pcm),
        .enc_code  (enc_code),
        .enc_done  (enc_done)
    );

    mulaw_decoder u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_code  (dec_code),
        .dec_pcm   (dec_pcm),
        .dec_done  (dec_done)
    );

endmodule

`default_nettype wire

/* verif/codec_tb.sv */
// mu-law codec testbench: directed tests checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module codec_tb import codec_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int N_CORNER   = 33;
    localparam int N_TABLE    = 260;
    localparam int N_MIXED    = 200;
    localparam int N_ROUND    = 48;
    localparam int N_BUSY     = 6;
    localparam int N_STROBES  = N_CORNER + N_TABLE + N_MIXED + 2 * N_ROUND + N_BUSY;
    // isolated strobes wait out the whole pipeline
    localparam int WATCHDOG_CYCLES = N_STROBES * (PIPE_LAT + 2) + 200;

    typedef struct packed {
        logic             is_enc;
        logic [PCM_W-1:0] value;
        int               due;
    } exp_item_t;

    logic              clk;
    logic              rst_n;
    logic              sample_valid;
    op_t               op;
    logic [PCM_W-1:0]  pcm_in;
    logic [CODE_W-1:0] code_in;
    wire  [CODE_W-1:0] code_out;
    wire  [PCM_W-1:0]  pcm_out;
    wire               out_valid;
    wire               busy;

    exp_item_t         exp_q[$];
    exp_item_t         mon_item;
    logic [CODE_W-1:0] exp_code;
    logic [PCM_W-1:0]  exp_pcm;
    logic [31:0]       lfsr_state;
    int                cyc;
    int                last_strobe_cyc;
    int                mismatches;
    int                failures;

    pcm_codec_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .op           (op),
        .pcm_in       (pcm_in),
        .code_in      (code_in),
        .code_out     (code_out),
        .pcm_out      (pcm_out),
        .out_valid    (out_valid),
        .busy         (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [CODE_W-1:0] ref_encode(input logic [PCM_W-1:0] x);
        int mag;
        int e;
        mag = int'($signed(x));
        if (mag < 0) mag = -mag;
        // -32768 lands above the clip as well
        if (mag > MULAW_CLIP) mag = MULAW_CLIP;
        mag = mag + MULAW_BIAS;
        e = 7;
        while (e > 0 && mag < (1 << (e + 7))) e--;
        return ~{x[PCM_W-1], 3'(e), 4'(mag >> (e + 3))};
    endfunction

    function automatic logic [PCM_W-1:0] ref_decode(input logic [CODE_W-1:0] code);
        logic [CODE_W-1:0] inv;
        int                mag;
        inv = ~code;
        mag = ((int'(inv[3:0]) * 8 + MULAW_BIAS) << inv[6:4]) - MULAW_BIAS;
        return inv[7] ? PCM_W'(-mag) : PCM_W'(mag);
    endfunction

    task automatic drive_strobe(input op_t o, input logic [PCM_W-1:0] pcm,
                                input logic [CODE_W-1:0] code);
        exp_item_t item;
        sample_valid = 1'b1;
        op = o;
        pcm_in = pcm;
        code_in = code;
        item.is_enc = (o == OP_ENCODE);
        item.value = item.is_enc ? PCM_W'(ref_encode(pcm)) : ref_decode(code);
        item.due = cyc + PIPE_LAT + 1;
        exp_q.push_back(item);
        last_strobe_cyc = cyc;
        @(negedge clk);
    endtask

    task automatic drive_idle();
        sample_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_idle();
        drive_idle();
        while (exp_q.size() != 0) begin
            drive_idle();
        end
    endtask

    // in-order result checker that also watches the unselected output
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                assert (exp_q.size() != 0) else begin
                    failures++;
                    $display("unexpected out_valid at %0t ns with nothing in flight", $time);
                end
                if (exp_q.size() != 0) begin
                    mon_item = exp_q.pop_front();
                    assert (mon_item.due == cyc) else begin
                        failures++;
                        $display("out_valid at %0t ns came in cycle %0d instead of cycle %0d",
                                 $time, cyc, mon_item.due);
                    end
                    if (mon_item.is_enc) exp_code = mon_item.value[CODE_W-1:0];
                    else exp_pcm = mon_item.value;
                end
            end else if (exp_q.size() != 0) begin
                assert (exp_q[0].due > cyc) else begin
                    mon_item = exp_q.pop_front();
                    failures++;
                    $display("out_valid missing at %0t ns for the result due in cycle %0d",
                             $time, mon_item.due);
                end
            end
            assert (code_out == exp_code) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: code_out %h, expected %h",
                         $time, code_out, exp_code);
            end
            assert (pcm_out == exp_pcm) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: pcm_out %h, expected %h",
                         $time, pcm_out, exp_pcm);
            end
        end
    end

    task automatic reset_state_check();
        assert (!out_valid && !busy && code_out == '0 && pcm_out == '0) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: outputs not cleared by reset", $time);
        end
    endtask

    task automatic encode_one(input logic [PCM_W-1:0] x);
        drive_strobe(OP_ENCODE, x, '0);
        wait_idle();
    endtask

    task automatic encode_corners();
        int b;
        encode_one(16'h0000);
        encode_one(16'h0001);
        encode_one(16'hFFFF);
        encode_one(16'h7FFF);
        encode_one(16'h8000);
        // both sides of each segment edge
        for (int e = 1; e < 8; e++) begin
            b = (1 << (e + 7)) - MULAW_BIAS;
            encode_one(PCM_W'(b));
            encode_one(PCM_W'(b - 1));
            encode_one(PCM_W'(-b));
            encode_one(PCM_W'(1 - b));
        end
    endtask

    task automatic zero_code_check(input logic [CODE_W-1:0] code);
        drive_strobe(OP_DECODE, '0, {code[CODE_W-1], 7'h00});
        drive_strobe(OP_DECODE, '0, code);
        wait_idle();
        assert (pcm_out == '0) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: code %h gave %h, expected 0", $time, code, pcm_out);
        end
    endtask

    task automatic decode_table();
        for (int i = 0; i < 256; i++) begin
            drive_strobe(OP_DECODE, '0, CODE_W'(i));
        end
        wait_idle();
        zero_code_check(8'h7F);
        zero_code_check(8'hFF);
    endtask

    task automatic mixed_traffic();
        logic [31:0] r;
        op_t         o;
        for (int i = 0; i < N_MIXED; i++) begin
            r = lfsr_bits(1);
            o = r[0] ? OP_ENCODE : OP_DECODE;
            drive_strobe(o, PCM_W'(lfsr_bits(16)), CODE_W'(lfsr_bits(8)));
        end
        wait_idle();
    endtask

    task automatic round_trip();
        logic [PCM_W-1:0]  x;
        logic [CODE_W-1:0] c;
        int                mag;
        int                err;
        for (int i = 0; i < N_ROUND; i++) begin
            x = PCM_W'(lfsr_bits(16));
            encode_one(x);
            c = code_out;
            drive_strobe(OP_DECODE, '0, c);
            wait_idle();
            mag = int'($signed(x));
            if (mag < 0) mag = -mag;
            if (mag > MULAW_CLIP) mag = MULAW_CLIP;
            err = int'($signed(pcm_out)) - (x[PCM_W-1] ? -mag : mag);
            if (err < 0) err = -err;
            // half a quantization step of the segment
            assert (err <= (4 << (~c[6:4]))) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: %h came back as %h, error %0d",
                         $time, x, pcm_out, err);
            end
        end
    endtask

    task automatic busy_flag();
        wait_idle();
        assert (!busy) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: busy high while idle", $time);
        end
        for (int i = 0; i < N_BUSY; i++) begin
            drive_strobe(i[0] ? OP_ENCODE : OP_DECODE, PCM_W'(lfsr_bits(16)), '0);
            assert (busy) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: busy low during burst", $time);
            end
        end
        drive_idle();
        while (cyc - last_strobe_cyc < PIPE_LAT + 1) begin
            assert (busy) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: busy fell early", $time);
            end
            drive_idle();
        end
        assert (!busy) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: busy still high after the last result", $time);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        sample_valid = 1'b0;
        op = OP_DECODE;
        pcm_in = '0;
        code_in = '0;
        exp_code = '0;
        exp_pcm = '0;
        lfsr_state = 32'h259b_365e;
        last_strobe_cyc = 0;
        mismatches = 0;
        failures = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state_check();
        encode_corners();
        decode_table();
        mixed_traffic();
        round_trip();
        busy_flag();
        repeat (2) drive_idle();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
